// File: ecc_ram_cfg.svh
/*
  Build settings for the single-port SECDED RAM.
  The Hamming field covers positions 1 to CODE_WIDTH-1 and position 0 holds
  the overall parity bit. Both latencies must be 1 or more. The check-bit
  count assumes a power-of-two data width.
*/
`ifndef ECC_RAM_CFG_SVH
`define ECC_RAM_CFG_SVH

// User data word width in bits
`define ECC_DATA_WIDTH 8

// Number of stored words and the address width that selects one
`define ECC_MEM_DEPTH 16
`define ECC_ADDR_WIDTH ($clog2(`ECC_MEM_DEPTH))

// Hamming check bits, log2 of the data width plus one
`define ECC_PARITY_BITS ($clog2(`ECC_DATA_WIDTH) + 1)

// Data plus check bits plus the overall parity bit
`define ECC_CODE_WIDTH (`ECC_DATA_WIDTH + `ECC_PARITY_BITS + 1)

// Register stages between the front end and the array on the command path
`define ECC_WR_LATENCY 3

// Register stages between the array read register and the result stage
`define ECC_RD_LATENCY 2

`endif

// File: ecc_ram_pkg.sv
/*
  Types shared by the SECDED RAM blocks.
  A codeword is one 13-bit word seen two ways. The flat view is indexed by
  Hamming position with bit 0 as the overall parity. The field view splits
  that parity bit off from the Hamming field.
*/
`include "ecc_ram_cfg.svh"

package ecc_ram_pkg;

  // Field view of a codeword
  // The Hamming field keeps its position numbering so bit n is position n
  typedef struct packed {
    logic [`ECC_CODE_WIDTH-1:1] hamming;
    logic                       parity;
  } code_fields_t;

  // One stored word, decoded either by position or by field
  // The encoder and the syndrome logic walk the flat view
  // The overall parity check in the result stage uses the field view
  typedef union packed {
    logic [`ECC_CODE_WIDTH-1:0] flat;
    code_fields_t               fields;
  } code_word_t;

  // Command carried down the write delay line
  // A read command still carries a codeword field, which the array ignores
  typedef struct packed {
    logic                       we;
    logic [`ECC_ADDR_WIDTH-1:0] addr;
    code_word_t                 code;
  } cmd_t;

endpackage

// File: cmd_decode.sv
/*
  Request front end with a four-phase req/ack handshake.
  Only one request is in flight. Inputs must stay stable while i_req is high.
  The flip mask is XORed into the stored codeword on writes only in effect,
  since a read command ignores its codeword field.
*/
`timescale 1ns/1ps
`include "ecc_ram_cfg.svh"

module cmd_decode
  import ecc_ram_pkg::*;
(
  input  logic                       clka,
  input  logic                       i_arst_n,
  input  logic                       i_req,
  input  logic                       i_we,
  input  logic [`ECC_ADDR_WIDTH-1:0] i_addr,
  input  logic [`ECC_DATA_WIDTH-1:0] i_wdata,
  input  logic [`ECC_CODE_WIDTH-1:0] i_flip_mask,
  input  logic                       i_wr_done,
  input  logic                       i_rd_done,
  output logic                       o_cmd_valid,
  output cmd_t                       o_cmd,
  output logic                       o_ack
);

  typedef enum logic [1:0] {S_IDLE, S_BUSY, S_ACK} state_t;

  state_t     state;
  code_word_t enc_word;
  logic       accept;
  logic       done;

  // Builds the SECDED codeword for one data word
  function automatic code_word_t secded_encode(input logic [`ECC_DATA_WIDTH-1:0] data);
    code_word_t cw;
    int         k;
    logic       par;
    cw = '0;
    k  = 0;
    // Data bits fill every position that is not a power of two, in order
    for (int pos = 1; pos < `ECC_CODE_WIDTH; pos++)
    begin
      if ((pos & (pos - 1)) != 0)
      begin
        cw.flat[pos] = data[k];
        k++;
      end
    end
    // Check bit 2**p covers every data position whose index has bit p set
    for (int p = 0; p < `ECC_PARITY_BITS; p++)
    begin
      par = 1'b0;
      for (int pos = 1; pos < `ECC_CODE_WIDTH; pos++)
      begin
        if ((((pos >> p) & 1) == 1) && ((pos & (pos - 1)) != 0))
          par = par ^ cw.flat[pos];
      end
      cw.flat[1 << p] = par;
    end
    // Overall parity makes the whole word even, which separates single from double
    cw.flat[0] = ^cw.flat[`ECC_CODE_WIDTH-1:1];
    return cw;
  endfunction

  // Encode then corrupt on purpose where the mask has ones
  always_comb
  begin
    enc_word      = secded_encode(i_wdata);
    enc_word.flat = enc_word.flat ^ i_flip_mask;
  end

  // A request is taken only from idle, which is the only back-pressure
  assign accept = (state == S_IDLE) && i_req;

  // Writes finish when the command leaves the write line, reads when data is decoded
  assign done = o_cmd.we ? i_wr_done : i_rd_done;

  always_ff @(posedge clka or negedge i_arst_n)
  begin
    if (!i_arst_n)
    begin
      state       <= S_IDLE;
      o_cmd_valid <= 1'b0;
      o_ack       <= 1'b0;
    end
    else
    begin
      // One-cycle command pulse per accepted request
      o_cmd_valid <= accept;
      case (state)
        S_IDLE:
        begin
          if (i_req)
            state <= S_BUSY;
        end
        S_BUSY:
        begin
          if (done)
          begin
            state <= S_ACK;
            o_ack <= 1'b1;
          end
        end
        S_ACK:
        begin
          // Ack drops on the edge that sees the request gone
          if (!i_req)
          begin
            state <= S_IDLE;
            o_ack <= 1'b0;
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  // Command payload is held for the whole transaction so done can look at we
  always_ff @(posedge clka)
  begin
    if (accept)
    begin
      o_cmd.we   <= i_we;
      o_cmd.addr <= i_addr;
      o_cmd.code <= enc_word;
    end
  end

endmodule

// File: latency_pipe.sv
/*
  Fixed-depth delay line for a valid bit and its payload.
  STAGES must be 1 or more. Every stage is a register, so the output lags
  the input by exactly STAGES clocks. There is no stall. Payload bits hold
  unknown values after reset until the first valid item passes.
*/
`timescale 1ns/1ps

module latency_pipe #(
  parameter int STAGES = 1,
  parameter int WIDTH  = 8
) (
  input  logic             clka,
  input  logic             i_arst_n,
  input  logic             i_valid,
  input  logic [WIDTH-1:0] i_data,
  output logic             o_valid,
  output logic [WIDTH-1:0] o_data
);

  // Stage 0 is next to the input and stage STAGES-1 drives the output
  logic [STAGES-1:0] valid_q;
  logic [WIDTH-1:0]  data_q [STAGES];

  // Valid bits are control and clear on reset
  always_ff @(posedge clka or negedge i_arst_n)
  begin
    if (!i_arst_n)
    begin
      valid_q <= '0;
    end
    else
    begin
      valid_q[0] <= i_valid;
      for (int s = 1; s < STAGES; s++)
        valid_q[s] <= valid_q[s-1];
    end
  end

  // Payload shifts every clock whether or not it is valid
  always_ff @(posedge clka)
  begin
    data_q[0] <= i_data;
    for (int s = 1; s < STAGES; s++)
      data_q[s] <= data_q[s-1];
  end

  assign o_valid = valid_q[STAGES-1];
  assign o_data  = data_q[STAGES-1];

endmodule

// File: ecc_ram_array.sv
/*
  Codeword storage for the SECDED RAM, one port, registered read.
  Contents are not initialised, so a read of an unwritten address returns
  unknown data and flags. Write and read never occur in the same cycle,
  because a command is either one or the other.
*/
`timescale 1ns/1ps
`include "ecc_ram_cfg.svh"

module ecc_ram_array
  import ecc_ram_pkg::*;
(
  input  logic       clka,
  input  logic       i_arst_n,
  input  logic       i_valid,
  input  cmd_t       i_cmd,
  output logic       o_rd_valid,
  output code_word_t o_rd_word
);

  // Whole codewords are stored, check bits and parity included
  code_word_t mem [`ECC_MEM_DEPTH];

  logic wr_en;
  logic rd_en;

  assign wr_en = i_valid && i_cmd.we;
  assign rd_en = i_valid && !i_cmd.we;

  // Write port
  always_ff @(posedge clka)
  begin
    if (wr_en)
      mem[i_cmd.addr] <= i_cmd.code;
  end

  // Read data register, updated only by a read command
  always_ff @(posedge clka)
  begin
    if (rd_en)
      o_rd_word <= mem[i_cmd.addr];
  end

  // Read valid pulse lines up with the registered word
  always_ff @(posedge clka or negedge i_arst_n)
  begin
    if (!i_arst_n)
      o_rd_valid <= 1'b0;
    else
      o_rd_valid <= rd_en;
  end

endmodule

// File: secded_result.sv
/*
  SECDED decode of a read codeword with registered outputs.
  Single errors are corrected, including an error on the parity bit alone.
  Double errors are flagged and the data is then not trustworthy. Three or
  more bit errors may be miscorrected. Outputs hold until the next read.
*/
`timescale 1ns/1ps
`include "ecc_ram_cfg.svh"

module secded_result
  import ecc_ram_pkg::*;
(
  input  logic                       clka,
  input  logic                       i_arst_n,
  input  logic                       i_valid,
  input  code_word_t                 i_word,
  output logic                       o_done,
  output logic [`ECC_DATA_WIDTH-1:0] o_rdata,
  output logic                       o_err_single,
  output logic                       o_err_double
);

  logic [`ECC_PARITY_BITS-1:0] syndrome;
  logic                        parity_odd;
  code_word_t                  fixed_word;
  logic [`ECC_DATA_WIDTH-1:0]  data_out;
  logic                        single_err;
  logic                        double_err;

  // Syndrome is the XOR of the positions of all set bits in the Hamming field
  always_comb
  begin
    syndrome = '0;
    for (int pos = 1; pos < `ECC_CODE_WIDTH; pos++)
    begin
      if (i_word.flat[pos])
        syndrome = syndrome ^ pos[`ECC_PARITY_BITS-1:0];
    end
  end

  // A stored word has even weight, so odd weight means an odd number of flips
  assign parity_odd = i_word.fields.parity ^ (^i_word.fields.hamming);

  always_comb
  begin
    fixed_word = i_word;
    single_err = 1'b0;
    double_err = 1'b0;
    if (syndrome != '0)
    begin
      // Odd weight and an in-range syndrome points at the one bad bit
      if (parity_odd && (syndrome < `ECC_CODE_WIDTH))
      begin
        fixed_word.flat[syndrome] = ~i_word.flat[syndrome];
        single_err                = 1'b1;
      end
      else
      begin
        // Even weight with a syndrome, or a syndrome past the last position
        double_err = 1'b1;
      end
    end
    else if (parity_odd)
    begin
      // Only the overall parity bit flipped and the data is intact
      single_err = 1'b1;
    end
  end

  // Pull the data bits back out of the non power-of-two positions
  always_comb
  begin
    int k;
    data_out = '0;
    k        = 0;
    for (int pos = 1; pos < `ECC_CODE_WIDTH; pos++)
    begin
      if ((pos & (pos - 1)) != 0)
      begin
        data_out[k] = fixed_word.flat[pos];
        k++;
      end
    end
  end

  always_ff @(posedge clka or negedge i_arst_n)
  begin
    if (!i_arst_n)
    begin
      o_done       <= 1'b0;
      o_err_single <= 1'b0;
      o_err_double <= 1'b0;
    end
    else
    begin
      o_done <= i_valid;
      if (i_valid)
      begin
        o_err_single <= single_err;
        o_err_double <= double_err;
      end
    end
  end

  // Read data is payload and holds until the next decoded word
  always_ff @(posedge clka)
  begin
    if (i_valid)
      o_rdata <= data_out;
  end

endmodule

// File: ecc_ram_top.sv
/*
  Single-port RAM with SECDED protection and configurable latencies.
  Handshake is four-phase req/ack with one request in flight. A write acks
  1 + WR_LATENCY clocks after i_req is sampled, a read acks
  3 + WR_LATENCY + RD_LATENCY clocks after. Read outputs are valid while
  o_ack is high after a read. i_flip_mask injects errors into stored words.
*/
`timescale 1ns/1ps
`include "ecc_ram_cfg.svh"

module ecc_ram_top (
  input  logic                       clka,
  input  logic                       i_arst_n,
  input  logic                       i_req,
  input  logic                       i_we,
  input  logic [`ECC_ADDR_WIDTH-1:0] i_addr,
  input  logic [`ECC_DATA_WIDTH-1:0] i_wdata,
  input  logic [`ECC_CODE_WIDTH-1:0] i_flip_mask,
  output logic                       o_ack,
  output logic [`ECC_DATA_WIDTH-1:0] o_rdata,
  output logic                       o_err_single,
  output logic                       o_err_double
);

  // Command is the write flag, the address and the codeword
  localparam int CMD_WIDTH = 1 + `ECC_ADDR_WIDTH + `ECC_CODE_WIDTH;

  // Front end to write delay line
  logic                       cmd_valid;
  logic [CMD_WIDTH-1:0]       cmd;
  // Write delay line to array, valid also reports write completion
  logic                       wr_valid;
  logic [CMD_WIDTH-1:0]       wr_cmd;
  // Array read register to read delay line
  logic                       arr_rd_valid;
  logic [`ECC_CODE_WIDTH-1:0] arr_rd_word;
  // Read delay line to result stage
  logic                       dec_valid;
  logic [`ECC_CODE_WIDTH-1:0] dec_word;
  // Result stage back to the front end
  logic                       rd_done;

  cmd_decode u_cmd_decode (
    .clka        (clka),
    .i_arst_n    (i_arst_n),
    .i_req       (i_req),
    .i_we        (i_we),
    .i_addr      (i_addr),
    .i_wdata     (i_wdata),
    .i_flip_mask (i_flip_mask),
    .i_wr_done   (wr_valid),
    .i_rd_done   (rd_done),
    .o_cmd_valid (cmd_valid),
    .o_cmd       (cmd),
    .o_ack       (o_ack)
  );

  latency_pipe #(
    .STAGES (`ECC_WR_LATENCY),
    .WIDTH  (CMD_WIDTH)
  ) u_wr_pipe (
    .clka     (clka),
    .i_arst_n (i_arst_n),
    .i_valid  (cmd_valid),
    .i_data   (cmd),
    .o_valid  (wr_valid),
    .o_data   (wr_cmd)
  );

  ecc_ram_array u_ecc_ram_array (
    .clka       (clka),
    .i_arst_n   (i_arst_n),
    .i_valid    (wr_valid),
    .i_cmd      (wr_cmd),
    .o_rd_valid (arr_rd_valid),
    .o_rd_word  (arr_rd_word)
  );

  latency_pipe #(
    .STAGES (`ECC_RD_LATENCY),
    .WIDTH  (`ECC_CODE_WIDTH)
  ) u_rd_pipe (
    .clka     (clka),
    .i_arst_n (i_arst_n),
    .i_valid  (arr_rd_valid),
    .i_data   (arr_rd_word),
    .o_valid  (dec_valid),
    .o_data   (dec_word)
  );

  secded_result u_secded_result (
    .clka         (clka),
    .i_arst_n     (i_arst_n),
    .i_valid      (dec_valid),
    .i_word       (dec_word),
    .o_done       (rd_done),
    .o_rdata      (o_rdata),
    .o_err_single (o_err_single),
    .o_err_double (o_err_double)
  );

endmodule

// File: ecc_ram_sva.sv
/*
  Handshake and flag assertions for the SECDED RAM, bound into the top level.
  Latency checks assume the master raises i_req only while o_ack is low.
  Each assertion also counts its failures so the testbench can see them.
*/
`timescale 1ns/1ps
`include "ecc_ram_cfg.svh"

module ecc_ram_sva (
  input logic clka,
  input logic i_arst_n,
  input logic i_req,
  input logic i_we,
  input logic o_ack,
  input logic o_err_single,
  input logic o_err_double
);

  int wr_ack_errs   = 0;
  int rd_ack_errs   = 0;
  int ack_req_errs  = 0;
  int flag_errs     = 0;

  // Sampled values trail the register update by one edge
  // so an ack set N clocks after the request is seen rises in the sample at N + 1
  a_wr_ack_latency: assert property (@(posedge clka) disable iff (!i_arst_n)
    ($rose(i_req) && i_we && !o_ack) |-> ##(`ECC_WR_LATENCY + 2) $rose(o_ack))
    else
    begin
      $error("Write ack did not rise 1 + write latency clocks after the request");
      wr_ack_errs++;
    end

  // Read path adds the array register, the read line and the result register
  a_rd_ack_latency: assert property (@(posedge clka) disable iff (!i_arst_n)
    ($rose(i_req) && !i_we && !o_ack) |-> ##(`ECC_WR_LATENCY + `ECC_RD_LATENCY + 4) $rose(o_ack))
    else
    begin
      $error("Read ack did not rise at the expected read latency");
      rd_ack_errs++;
    end

  // The master may drop i_req on the falling edge right after it sees ack
  a_ack_needs_req: assert property (@(posedge clka) disable iff (!i_arst_n)
    $rose(o_ack) |-> $past(i_req))
    else
    begin
      $error("Ack rose without an active request");
      ack_req_errs++;
    end

  a_flags_exclusive: assert property (@(posedge clka) disable iff (!i_arst_n)
    !(o_err_single && o_err_double))
    else
    begin
      $error("Single and double error flags are high together");
      flag_errs++;
    end

endmodule

// File: tb_ecc_ram.sv
/*
  Testbench for the SECDED RAM, driven from ecc_ram_patterns.txt.
  Run from the project root so the pattern file is found. Ops are W write,
  R read and check, D read with data ignored, F random fill of every address
  and V read back of every address in reverse order.
*/
`timescale 1ns/1ps
`include "ecc_ram_cfg.svh"

module tb_ecc_ram;

  localparam int CLK_HALF      = 20;
  localparam int RESET_CYCLES  = 4;
  // Generous bound on the clocks one handshake may take
  localparam int CYCLES_PER_OP = 20;

  logic                       clka;
  logic                       i_arst_n;
  logic                       i_req;
  logic                       i_we;
  logic [`ECC_ADDR_WIDTH-1:0] i_addr;
  logic [`ECC_DATA_WIDTH-1:0] i_wdata;
  logic [`ECC_CODE_WIDTH-1:0] i_flip_mask;
  logic                       o_ack;
  logic [`ECC_DATA_WIDTH-1:0] o_rdata;
  logic                       o_err_single;
  logic                       o_err_double;

  // One entry per pattern line
  string                      op_q[$];
  logic [`ECC_ADDR_WIDTH-1:0] addr_q[$];
  logic [`ECC_DATA_WIDTH-1:0] data_q[$];
  logic [`ECC_CODE_WIDTH-1:0] mask_q[$];
  logic [`ECC_DATA_WIDTH-1:0] exp_data_q[$];
  logic                       exp_single_q[$];
  logic                       exp_double_q[$];

  // Data written by the fill sweep, indexed by address
  logic [`ECC_DATA_WIDTH-1:0] shadow [`ECC_MEM_DEPTH];

  // Read results captured while ack is high
  logic [`ECC_DATA_WIDTH-1:0] got_data;
  logic                       got_single;
  logic                       got_double;

  int limit_cycles = 0;
  int test_count   = 0;
  int fail_count   = 0;

  ecc_ram_top uut (
    .clka         (clka),
    .i_arst_n     (i_arst_n),
    .i_req        (i_req),
    .i_we         (i_we),
    .i_addr       (i_addr),
    .i_wdata      (i_wdata),
    .i_flip_mask  (i_flip_mask),
    .o_ack        (o_ack),
    .o_rdata      (o_rdata),
    .o_err_single (o_err_single),
    .o_err_double (o_err_double)
  );

  bind ecc_ram_top ecc_ram_sva u_sva (
    .clka         (clka),
    .i_arst_n     (i_arst_n),
    .i_req        (i_req),
    .i_we         (i_we),
    .o_ack        (o_ack),
    .o_err_single (o_err_single),
    .o_err_double (o_err_double)
  );

  always #(CLK_HALF) clka = ~clka;

  task automatic load_patterns(output logic loaded);
    int                         fd;
    int                         n;
    string                      line;
    string                      op;
    logic [`ECC_ADDR_WIDTH-1:0] a;
    logic [`ECC_DATA_WIDTH-1:0] d;
    logic [`ECC_CODE_WIDTH-1:0] m;
    logic [`ECC_DATA_WIDTH-1:0] ed;
    logic                       es;
    logic                       edd;
    loaded = 1'b0;
    fd = $fopen("ecc_ram_patterns.txt", "r");
    if (fd != 0)
    begin
      while (!$feof(fd))
      begin
        if ($fgets(line, fd) != 0)
        begin
          n = $sscanf(line, "%s %h %h %h %h %b %b", op, a, d, m, ed, es, edd);
          // Comment and blank lines never yield all seven fields
          if (n == 7)
          begin
            op_q.push_back(op);
            addr_q.push_back(a);
            data_q.push_back(d);
            mask_q.push_back(m);
            exp_data_q.push_back(ed);
            exp_single_q.push_back(es);
            exp_double_q.push_back(edd);
          end
        end
      end
      $fclose(fd);
      loaded = 1'b1;
    end
  endtask

  // One four-phase transfer, also checks that ack falls one clock after req drops
  task automatic run_handshake(input logic we, input logic [`ECC_ADDR_WIDTH-1:0] addr,
                               input logic [`ECC_DATA_WIDTH-1:0] data,
                               input logic [`ECC_CODE_WIDTH-1:0] mask,
                               input string name, output logic hs_ok);
    hs_ok = 1'b1;
    @(negedge clka);
    i_we        = we;
    i_addr      = addr;
    i_wdata     = data;
    i_flip_mask = mask;
    i_req       = 1'b1;
    while (!o_ack)
      @(negedge clka);
    got_data   = o_rdata;
    got_single = o_err_single;
    got_double = o_err_double;
    i_req      = 1'b0;
    @(negedge clka);
    if (o_ack)
    begin
      $display("%s: ack still high one clock after the request dropped", name);
      hs_ok = 1'b0;
    end
    while (o_ack)
      @(negedge clka);
  endtask

  task automatic finish_test(input string name, input logic ok);
    test_count++;
    if (ok)
      $display("test %s passed", name);
    else
    begin
      fail_count++;
      $display("test %s failed", name);
    end
  endtask

  task automatic check_read(input string name, input logic [`ECC_DATA_WIDTH-1:0] exp_data,
                            input logic exp_single, input logic exp_double,
                            input logic check_data, input logic hs_ok);
    logic ok;
    ok = hs_ok;
    if (check_data && (got_data !== exp_data))
    begin
      $display("[FAIL] %s rdata expected %h actual %h", name, exp_data, got_data);
      ok = 1'b0;
    end
    if (got_single !== exp_single)
    begin
      $display("[FAIL] %s err_single expected %b actual %b", name, exp_single, got_single);
      ok = 1'b0;
    end
    if (got_double !== exp_double)
    begin
      $display("[FAIL] %s err_double expected %b actual %b", name, exp_double, got_double);
      ok = 1'b0;
    end
    finish_test(name, ok);
  endtask

  task automatic run_patterns();
    logic                       ok;
    logic [`ECC_DATA_WIDTH-1:0] d;
    string                      name;
    for (int i = 0; i < op_q.size(); i++)
    begin
      if (op_q[i] == "W")
      begin
        name = $sformatf("%0d_write_a%0h", i, addr_q[i]);
        run_handshake(1'b1, addr_q[i], data_q[i], mask_q[i], name, ok);
        finish_test(name, ok);
      end
      else if ((op_q[i] == "R") || (op_q[i] == "D"))
      begin
        name = $sformatf("%0d_read_a%0h", i, addr_q[i]);
        run_handshake(1'b0, addr_q[i], '0, '0, name, ok);
        check_read(name, exp_data_q[i], exp_single_q[i], exp_double_q[i], op_q[i] == "R", ok);
      end
      else if (op_q[i] == "F")
      begin
        for (int a = 0; a < `ECC_MEM_DEPTH; a++)
        begin
          d         = `ECC_DATA_WIDTH'($urandom);
          shadow[a] = d;
          name      = $sformatf("%0d_fill_a%0h", i, a);
          run_handshake(1'b1, `ECC_ADDR_WIDTH'(a), d, '0, name, ok);
          finish_test(name, ok);
        end
      end
      else if (op_q[i] == "V")
      begin
        // Reverse order so a stuck or aliased address shows up as a mismatch
        for (int a = `ECC_MEM_DEPTH - 1; a >= 0; a--)
        begin
          name = $sformatf("%0d_verify_a%0h", i, a);
          run_handshake(1'b0, `ECC_ADDR_WIDTH'(a), '0, '0, name, ok);
          check_read(name, shadow[a], 1'b0, 1'b0, 1'b1, ok);
        end
      end
      else
      begin
        $display("Unknown op %s on pattern line %0d", op_q[i], i);
        fail_count++;
      end
    end
  endtask

  initial
  begin
    logic loaded;
    int   ops;
    int   sva_fails;
    clka        = 1'b0;
    i_arst_n    = 1'b0;
    i_req       = 1'b0;
    i_we        = 1'b0;
    i_addr      = '0;
    i_wdata     = '0;
    i_flip_mask = '0;
    void'($urandom(69));
    load_patterns(loaded);
    if (!loaded)
    begin
      $display("Could not open the pattern file ecc_ram_patterns.txt");
      $display("Done: errors found");
      $finish;
    end
    else
    begin
      // Sweeps run one handshake per address
      ops = 0;
      foreach (op_q[i])
        ops += ((op_q[i] == "F") || (op_q[i] == "V")) ? `ECC_MEM_DEPTH : 1;
      limit_cycles = ops * CYCLES_PER_OP + RESET_CYCLES + 2;
      repeat (RESET_CYCLES) @(posedge clka);
      @(negedge clka);
      i_arst_n = 1'b1;
      run_patterns();
      sva_fails = uut.u_sva.wr_ack_errs + uut.u_sva.rd_ack_errs
                + uut.u_sva.ack_req_errs + uut.u_sva.flag_errs;
      $display("Tests: %0d, failed: %0d, assertion failures: %0d",
               test_count, fail_count, sva_fails);
      if ((fail_count == 0) && (sva_fails == 0))
        $display("Done: no errors");
      else
        $display("Done: errors found");
      $finish;
    end
  end

  // Watchdog, armed once the pattern count is known
  initial
  begin
    wait (limit_cycles > 0);
    repeat (limit_cycles) @(posedge clka);
    $display("Run timed out after %0d clocks, a handshake never completed", limit_cycles);
    $display("Done: errors found");
    $finish;
  end

endmodule

// File: ecc_ram_patterns.txt
# op addr data mask exp_data exp_single exp_double (hex fields, binary flags)
# W write, R read and check, D read with data ignored, F fill all, V verify all in reverse
W 3 a5 0000 00 0 0
R 3 00 0000 a5 0 0
W 5 3c 0008 00 0 0
R 5 00 0000 3c 1 0
W a 81 1000 00 0 0
R a 00 0000 81 1 0
W 7 5e 0010 00 0 0
R 7 00 0000 5e 1 0
W 6 c3 0001 00 0 0
R 6 00 0000 c3 1 0
W 9 7e 0060 00 0 0
D 9 00 0000 00 0 1
W c 42 0101 00 0 0
D c 00 0000 00 0 1
R 3 00 0000 a5 0 0
F 0 00 0000 00 0 0
V 0 00 0000 00 0 0
W 3 0f 0000 00 0 0
R 3 00 0000 0f 0 0

// File: compile.f
+incdir+.
ecc_ram_pkg.sv
cmd_decode.sv
latency_pipe.sv
ecc_ram_array.sv
secded_result.sv
ecc_ram_top.sv
ecc_ram_sva.sv
tb_ecc_ram.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build with Verilator, run from the project root, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --top-module tb_ecc_ram -f compile.f -o tb_ecc_ram \
  > build.log 2>&1 || { echo "Build failed, see build.log"; exit 1; }

./obj_dir/tb_ecc_ram +verilator+error+limit+100 > sim.log 2>&1 || echo "Simulator exited with an error"

grep -qx "Done: no errors" sim.log && echo "Simulation passed" \
  || { echo "Simulation failed, see sim.log"; exit 1; }
